// File: design/apb_cfg_regs.sv
//----------------------------------------------------------
// APB register file.
// Mode, gain, shift and offset, plus output word counter.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

module apb_cfg_regs (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [`STREAM_APB_AW-1:0]  paddr,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`STREAM_DATA_W-1:0]  pwdata,
   output logic [`STREAM_DATA_W-1:0]  prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic                       beat,
   output stream_pkg::scale_cfg_t     cfg
);

   logic                      access;
   logic                      wr_en;
   logic                      mapped;
   logic [`STREAM_DATA_W-1:0] count;

   assign access = psel & penable;
   assign wr_en  = access & pwrite;

   // No wait states.
   assign pready  = 1'b1;
   assign pslverr = access & ~mapped;

   // ----------------------------------------------------------
   // Read decode.
   // ----------------------------------------------------------
   always_comb begin
      prdata = '0;
      mapped = 1'b1;
      case (paddr)
         `REG_CTRL:   prdata = {{(`STREAM_DATA_W-1){1'b0}}, cfg.complex_mode};
         `REG_GAIN:   prdata = {{(`STREAM_DATA_W-`STREAM_GAIN_W){1'b0}}, cfg.gain};
         `REG_SHIFT:  prdata = {{(`STREAM_DATA_W-`STREAM_SHIFT_W){1'b0}}, cfg.shift};
         `REG_OFFSET: prdata = {{(`STREAM_DATA_W-`STREAM_LANE_W){1'b0}}, cfg.offset};
         `REG_COUNT:  prdata = count;
         default:     mapped = 1'b0;
      endcase
   end

   // ----------------------------------------------------------
   // Configuration registers.
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg.complex_mode <= 1'b0;
         cfg.gain         <= `STREAM_GAIN_W'sd1;
         cfg.shift        <= '0;
         cfg.offset       <= '0;
      end else if (wr_en) begin
         case (paddr)
            `REG_CTRL:   cfg.complex_mode <= pwdata[0];
            `REG_GAIN:   cfg.gain         <= pwdata[`STREAM_GAIN_W-1:0];
            `REG_SHIFT:  cfg.shift        <= pwdata[`STREAM_SHIFT_W-1:0];
            `REG_OFFSET: cfg.offset       <= pwdata[`STREAM_LANE_W-1:0];
            default: ;
         endcase
      end
   end

   // Output word counter, wraps. Clear wins over a beat.
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (wr_en && paddr == `REG_COUNT) begin
         count <= '0;
      end else if (beat) begin
         count <= count + 1'b1;
      end
   end

   // Access phase always follows a setup phase.
   a_apb_phase: assert property (@(posedge clk) disable iff (rst)
      penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

// File: design/axis_if.sv
//----------------------------------------------------------
// Sample stream interface.
// Valid/ready handshake with end-of-packet flag.
//----------------------------------------------------------
`default_nettype none

interface axis_if;

   stream_pkg::sample_word_u tdata;
   logic                     tvalid;
   logic                     tready;
   logic                     tlast;

   modport source (
      output tdata, tvalid, tlast,
      input  tready
   );

   modport sink (
      input  tdata, tvalid, tlast,
      output tready
   );

endinterface

`default_nettype wire

// File: design/axis_minimal_fifo.sv
//----------------------------------------------------------
// Two-entry stream FIFO.
// Ready and valid are both registered, so no combinational
// path runs from the downstream side to the upstream side.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

module axis_minimal_fifo (
   input  logic        clk,
   input  logic        rst,
   axis_if.sink        in,
   axis_if.source      out,
   output logic [1:0]  occupied
);

   typedef enum logic [1:0] {
      EMPTY = 2'd0,
      HALF  = 2'd1,
      FULL  = 2'd2
   } state_t;

   state_t state;
   state_t state_nxt;

   // Entries carry {tlast, tdata}.
   logic [`STREAM_DATA_W:0] entry_new;
   logic [`STREAM_DATA_W:0] entry_old;
   logic [`STREAM_DATA_W:0] entry_head;

   logic push;
   logic pop;

   assign push = in.tvalid & in.tready;
   assign pop  = out.tvalid & out.tready;

   always_comb begin
      state_nxt = state;
      case (state)
         EMPTY: if (push) state_nxt = HALF;
         HALF: begin
            if (push && !pop) begin
               state_nxt = FULL;
            end else if (pop && !push) begin
               state_nxt = EMPTY;
            end
         end
         FULL: if (pop) state_nxt = HALF;
         default: state_nxt = EMPTY;
      endcase
   end

   // ----------------------------------------------------------
   // Control registers.
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= EMPTY;
         in.tready  <= 1'b1;
         out.tvalid <= 1'b0;
         occupied   <= 2'd0;
      end else begin
         state      <= state_nxt;
         in.tready  <= (state_nxt != FULL);
         out.tvalid <= (state_nxt != EMPTY);
         occupied   <= state_nxt;
      end
   end

   // ----------------------------------------------------------
   // Data registers.
   // ----------------------------------------------------------
   // Newest beat always lands in entry_new; the older one moves
   // aside only when the FIFO fills.
   always_ff @(posedge clk) begin
      if (push) begin
         entry_new <= {in.tlast, in.tdata};
      end
      if (push && !pop && state == HALF) begin
         entry_old <= entry_new;
      end
   end

   assign entry_head = (state == FULL) ? entry_old : entry_new;
   assign out.tdata  = entry_head[`STREAM_DATA_W-1:0];
   assign out.tlast  = entry_head[`STREAM_DATA_W];

endmodule

`default_nettype wire

// File: design/sample_gain.sv
//----------------------------------------------------------
// Gain stage.
// Multiplies by the signed gain, shifts right and saturates,
// per lane in complex mode or on the full word in real mode.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

module sample_gain (
   input  logic                    clk,
   input  logic                    rst,
   axis_if.sink                    in,
   axis_if.source                  out,
   input  stream_pkg::scale_cfg_t  cfg
);

   localparam int LANE_PW = `STREAM_LANE_W + `STREAM_GAIN_W;
   localparam int WORD_PW = `STREAM_DATA_W + `STREAM_GAIN_W;

   stream_pkg::sample_word_u result;

   // Lane product, shift and clamp to 16 bits.
   function automatic logic signed [`STREAM_LANE_W-1:0] scale_lane(
      input logic signed [`STREAM_LANE_W-1:0] x,
      input logic signed [`STREAM_GAIN_W-1:0] g,
      input logic [`STREAM_SHIFT_W-1:0]       sh
   );
      logic signed [LANE_PW-1:0] prod;
      logic signed [LANE_PW-1:0] shifted;
      logic                      s;
      prod    = x * g;
      shifted = prod >>> sh;
      s       = shifted[LANE_PW-1];
      // In range when every upper bit matches the sign.
      if (&shifted[LANE_PW-1:`STREAM_LANE_W-1] || ~|shifted[LANE_PW-1:`STREAM_LANE_W-1]) begin
         scale_lane = shifted[`STREAM_LANE_W-1:0];
      end else begin
         scale_lane = {s, {(`STREAM_LANE_W-1){~s}}};
      end
   endfunction

   // Same rule on the full 32-bit sample.
   function automatic logic signed [`STREAM_DATA_W-1:0] scale_word(
      input logic signed [`STREAM_DATA_W-1:0] x,
      input logic signed [`STREAM_GAIN_W-1:0] g,
      input logic [`STREAM_SHIFT_W-1:0]       sh
   );
      logic signed [WORD_PW-1:0] prod;
      logic signed [WORD_PW-1:0] shifted;
      logic                      s;
      prod    = x * g;
      shifted = prod >>> sh;
      s       = shifted[WORD_PW-1];
      if (&shifted[WORD_PW-1:`STREAM_DATA_W-1] || ~|shifted[WORD_PW-1:`STREAM_DATA_W-1]) begin
         scale_word = shifted[`STREAM_DATA_W-1:0];
      end else begin
         scale_word = {s, {(`STREAM_DATA_W-1){~s}}};
      end
   endfunction

   always_comb begin
      if (cfg.complex_mode) begin
         result.cplx.i = scale_lane(in.tdata.cplx.i, cfg.gain, cfg.shift);
         result.cplx.q = scale_lane(in.tdata.cplx.q, cfg.gain, cfg.shift);
      end else begin
         result.raw = scale_word(in.tdata.raw, cfg.gain, cfg.shift);
      end
   end

   // One-entry register slice, full throughput.
   assign in.tready = out.tready | ~out.tvalid;

   always_ff @(posedge clk) begin
      if (rst) begin
         out.tvalid <= 1'b0;
      end else if (in.tready) begin
         out.tvalid <= in.tvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (in.tvalid && in.tready) begin
         out.tdata <= result;
         out.tlast <= in.tlast;
      end
   end

   // A stalled beat keeps its payload until taken.
   a_stall_stable: assert property (@(posedge clk) disable iff (rst)
      out.tvalid && !out.tready |=> out.tvalid && $stable(out.tdata) && $stable(out.tlast));

endmodule

`default_nettype wire

// File: design/sample_offset.sv
//----------------------------------------------------------
// Offset stage.
// Adds the signed offset with saturation and flags each
// output beat for the word counter.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

module sample_offset (
   input  logic                    clk,
   input  logic                    rst,
   axis_if.sink                    in,
   axis_if.source                  out,
   input  stream_pkg::scale_cfg_t  cfg,
   output logic                    beat
);

   stream_pkg::sample_word_u result;

   function automatic logic signed [`STREAM_LANE_W-1:0] add_lane(
      input logic signed [`STREAM_LANE_W-1:0] x,
      input logic signed [`STREAM_LANE_W-1:0] off
   );
      logic signed [`STREAM_LANE_W:0] sum;
      sum = x + off;
      // Overflow when the carry bit disagrees with the sign.
      if (sum[`STREAM_LANE_W] != sum[`STREAM_LANE_W-1]) begin
         add_lane = {sum[`STREAM_LANE_W], {(`STREAM_LANE_W-1){~sum[`STREAM_LANE_W]}}};
      end else begin
         add_lane = sum[`STREAM_LANE_W-1:0];
      end
   endfunction

   function automatic logic signed [`STREAM_DATA_W-1:0] add_word(
      input logic signed [`STREAM_DATA_W-1:0] x,
      input logic signed [`STREAM_LANE_W-1:0] off
   );
      logic signed [`STREAM_DATA_W:0] sum;
      sum = x + off;
      if (sum[`STREAM_DATA_W] != sum[`STREAM_DATA_W-1]) begin
         add_word = {sum[`STREAM_DATA_W], {(`STREAM_DATA_W-1){~sum[`STREAM_DATA_W]}}};
      end else begin
         add_word = sum[`STREAM_DATA_W-1:0];
      end
   endfunction

   always_comb begin
      if (cfg.complex_mode) begin
         result.cplx.i = add_lane(in.tdata.cplx.i, cfg.offset);
         result.cplx.q = add_lane(in.tdata.cplx.q, cfg.offset);
      end else begin
         result.raw = add_word(in.tdata.raw, cfg.offset);
      end
   end

   assign in.tready = out.tready | ~out.tvalid;

   always_ff @(posedge clk) begin
      if (rst) begin
         out.tvalid <= 1'b0;
      end else if (in.tready) begin
         out.tvalid <= in.tvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (in.tvalid && in.tready) begin
         out.tdata <= result;
         out.tlast <= in.tlast;
      end
   end

   // High in the cycle the output beat transfers.
   assign beat = out.tvalid & out.tready;

   a_stall_stable: assert property (@(posedge clk) disable iff (rst)
      out.tvalid && !out.tready |=> out.tvalid && $stable(out.tdata) && $stable(out.tlast));

endmodule

`default_nettype wire

// File: design/stream_params.svh
//----------------------------------------------------------
// Stream scaler widths and APB register map.
//----------------------------------------------------------
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Datapath widths.
`define STREAM_DATA_W  32
`define STREAM_LANE_W  16
`define STREAM_GAIN_W  16
`define STREAM_SHIFT_W 5

// APB register offsets.
`define STREAM_APB_AW  8
`define REG_CTRL       8'h00
`define REG_GAIN       8'h04
`define REG_SHIFT      8'h08
`define REG_OFFSET     8'h0C
`define REG_COUNT      8'h10

`endif

// File: design/stream_pkg.sv
//----------------------------------------------------------
// Stream scaler types.
// Sample word decoding and scaling configuration.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

package stream_pkg;

   // Complex sample, Q in the upper half.
   typedef struct packed {
      logic signed [`STREAM_LANE_W-1:0] q;
      logic signed [`STREAM_LANE_W-1:0] i;
   } lane_pair_t;

   // One word, read as a real sample or as an I/Q pair.
   typedef union packed {
      logic signed [`STREAM_DATA_W-1:0] raw;
      lane_pair_t                       cplx;
   } sample_word_u;

   typedef struct packed {
      logic                             complex_mode;
      logic signed [`STREAM_GAIN_W-1:0] gain;
      logic [`STREAM_SHIFT_W-1:0]       shift;
      logic signed [`STREAM_LANE_W-1:0] offset;
   } scale_cfg_t;

endpackage

`default_nettype wire

// File: design/stream_scaler_top.sv
//----------------------------------------------------------
// Streaming sample scaler top level.
// Input FIFO, gain, offset and output FIFO, APB configured.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

module stream_scaler_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [`STREAM_DATA_W-1:0]  in_tdata,
   input  logic                       in_tvalid,
   input  logic                       in_tlast,
   output logic                       in_tready,
   output logic [`STREAM_DATA_W-1:0]  out_tdata,
   output logic                       out_tvalid,
   output logic                       out_tlast,
   input  logic                       out_tready,
   input  logic [`STREAM_APB_AW-1:0]  paddr,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`STREAM_DATA_W-1:0]  pwdata,
   output logic [`STREAM_DATA_W-1:0]  prdata,
   output logic                       pready,
   output logic                       pslverr
);

   axis_if s_in ();
   axis_if s_gain ();
   axis_if s_off ();
   axis_if s_out ();
   axis_if s_tx ();

   stream_pkg::scale_cfg_t cfg;
   logic                   beat;
   logic [1:0]             in_occ;
   logic [1:0]             out_occ;

   // Port side of the input FIFO.
   assign s_in.tdata = in_tdata;
   assign s_in.tvalid = in_tvalid;
   assign s_in.tlast = in_tlast;
   assign in_tready = s_in.tready;

   // Port side of the output FIFO.
   assign out_tdata = s_tx.tdata;
   assign out_tvalid = s_tx.tvalid;
   assign out_tlast = s_tx.tlast;
   assign s_tx.tready = out_tready;

   axis_minimal_fifo u_in_fifo (.clk, .rst, .in(s_in), .out(s_gain), .occupied(in_occ));

   sample_gain u_gain (.clk, .rst, .in(s_gain), .out(s_off), .cfg);

   sample_offset u_off (.clk, .rst, .in(s_off), .out(s_out), .cfg, .beat);

   axis_minimal_fifo u_out_fifo (.clk, .rst, .in(s_out), .out(s_tx), .occupied(out_occ));

   apb_cfg_regs u_regs (
      .clk, .rst,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .beat, .cfg
   );

   // FIFO depth never exceeds two and a full FIFO takes nothing.
   a_in_fifo_depth: assert property (@(posedge clk) disable iff (rst)
      in_occ != 2'd3 && !(in_occ == 2'd2 && s_in.tvalid && s_in.tready));
   a_out_fifo_depth: assert property (@(posedge clk) disable iff (rst)
      out_occ != 2'd3 && !(out_occ == 2'd2 && s_out.tvalid && s_out.tready));

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/stream_pkg.sv
design/axis_if.sv
design/axis_minimal_fifo.sv
design/sample_gain.sv
design/sample_offset.sv
design/apb_cfg_regs.sv
design/stream_scaler_top.sv
tests/tb_stream_scaler.sv

// File: tests/tb_stream_scaler.sv
//----------------------------------------------------------
// Stream scaler testbench.
// LFSR stimulus with back-pressure, reference model,
// in-order scoreboard and APB register checks.
//----------------------------------------------------------
`default_nettype none
`include "stream_params.svh"

module tb_stream_scaler;

   localparam int N_REAL_A  = 48;
   localparam int N_REAL_B  = 48;
   localparam int N_CPLX    = 64;
   localparam int N_CPLX_BP = 96;
   localparam int N_REAL_BP = 96;
   localparam int N_AFTER   = 16;
   localparam int TOTAL_WORDS = N_REAL_A + N_REAL_B + N_CPLX + N_CPLX_BP + N_REAL_BP + N_AFTER;
   localparam int APB_OVERHEAD = 400;
   localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + APB_OVERHEAD;

   logic        clk;
   logic        rst;
   logic [31:0] in_tdata;
   logic        in_tvalid;
   logic        in_tlast;
   logic        in_tready;
   logic [31:0] out_tdata;
   logic        out_tvalid;
   logic        out_tlast;
   logic        out_tready;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   // Expected words as {tlast, tdata}, oldest first.
   logic [32:0] exp_q[$];
   logic [32:0] exp_item;
   int          out_beats;
   logic [31:0] lfsr_state;

   // Configuration the reference model works from.
   logic              cur_mode;
   logic signed [15:0] cur_gain;
   logic [4:0]        cur_shift;
   logic signed [15:0] cur_offset;

   stream_scaler_top dut (
      .clk, .rst,
      .in_tdata, .in_tvalid, .in_tlast, .in_tready,
      .out_tdata, .out_tvalid, .out_tlast, .out_tready,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ----------------------------------------------------------
   // Random numbers and reference model.
   // ----------------------------------------------------------
   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      int          k;
      r = '0;
      for (k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic longint clamp(input longint v, input int bits);
      longint hi;
      longint lo;
      hi = (longint'(1) <<< (bits - 1)) - 1;
      lo = -hi - 1;
      if (v > hi) return hi;
      if (v < lo) return lo;
      return v;
   endfunction

   // Multiply, floor shift, clamp, add offset, clamp again.
   function automatic longint scale_value(input longint x, input longint g, input int sh,
                                          input longint off, input int bits);
      longint p;
      p = (x * g) >>> sh;
      p = clamp(p, bits);
      return clamp(p + off, bits);
   endfunction

   function automatic logic [31:0] ref_scale(input logic [31:0] x);
      longint i_res;
      longint q_res;
      longint w_res;
      logic [31:0] r;
      if (cur_mode) begin
         i_res = scale_value(longint'($signed(x[15:0])), longint'(cur_gain), int'(cur_shift),
                             longint'(cur_offset), 16);
         q_res = scale_value(longint'($signed(x[31:16])), longint'(cur_gain), int'(cur_shift),
                             longint'(cur_offset), 16);
         r = {q_res[15:0], i_res[15:0]};
      end else begin
         w_res = scale_value(longint'($signed(x)), longint'(cur_gain), int'(cur_shift),
                             longint'(cur_offset), 32);
         r = w_res[31:0];
      end
      return r;
   endfunction

   task automatic fail_now(input string msg);
      $display("error at %0t: %s", $time, msg);
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   // ----------------------------------------------------------
   // APB access tasks.
   // ----------------------------------------------------------
   task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(negedge clk);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      assert (pready) else fail_now("pready low in access phase");
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_access(addr, 1'b1, data, rd, err);
      assert (!err) else fail_now($sformatf("pslverr on write to %h", addr));
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
      logic [31:0] rd;
      logic        err;
      apb_access(addr, 1'b0, 32'h0, rd, err);
      assert (!err && rd == expected)
         else fail_now($sformatf("reg %h expected %h got %h (pslverr %b)", addr, expected, rd, err));
   endtask

   task automatic check_config();
      check_reg(`REG_CTRL, {31'h0, cur_mode});
      check_reg(`REG_GAIN, {16'h0, cur_gain});
      check_reg(`REG_SHIFT, {27'h0, cur_shift});
      check_reg(`REG_OFFSET, {16'h0, cur_offset});
   endtask

   task automatic set_config(input logic mode, input logic signed [15:0] gain,
                             input logic [4:0] shift, input logic signed [15:0] offset);
      reg_write(`REG_CTRL, {31'h0, mode});
      reg_write(`REG_GAIN, {16'h0, gain});
      reg_write(`REG_SHIFT, {27'h0, shift});
      reg_write(`REG_OFFSET, {16'h0, offset});
      cur_mode   = mode;
      cur_gain   = gain;
      cur_shift  = shift;
      cur_offset = offset;
      check_config();
   endtask

   // ----------------------------------------------------------
   // Stream stimulus.
   // ----------------------------------------------------------
   // With bp set, inputs get gaps and out_tready toggles randomly.
   task automatic send_words(input int n, input logic bp);
      int   sent;
      logic pending;
      sent    = 0;
      pending = 1'b0;
      while (sent < n) begin
         @(negedge clk);
         out_tready = bp ? (take_bits(1) != 0) : 1'b1;
         if (!pending) begin
            if (bp && take_bits(2) == 0) begin
               in_tvalid = 1'b0;
            end else begin
               in_tdata  = take_bits(32);
               in_tlast  = (take_bits(1) != 0);
               in_tvalid = 1'b1;
               pending   = 1'b1;
            end
         end
         @(posedge clk);
         if (in_tvalid && in_tready) begin
            exp_q.push_back({in_tlast, ref_scale(in_tdata)});
            pending = 1'b0;
            sent++;
         end
      end
      @(negedge clk);
      in_tvalid = 1'b0;
   endtask

   task automatic drain(input logic bp);
      while (exp_q.size() != 0) begin
         @(negedge clk);
         out_tready = bp ? (take_bits(1) != 0) : 1'b1;
      end
      @(negedge clk);
      out_tready = 1'b1;
   endtask

   // Scoreboard, one pop per output beat.
   always @(posedge clk) begin
      if (!rst && out_tvalid && out_tready) begin
         assert (exp_q.size() != 0) else fail_now("output beat with no word outstanding");
         exp_item = exp_q.pop_front();
         assert (out_tdata == exp_item[31:0] && out_tlast == exp_item[32])
            else fail_now($sformatf("expected data %h last %b, got data %h last %b",
                                    exp_item[31:0], exp_item[32], out_tdata, out_tlast));
         out_beats++;
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("watchdog: run timed out after %0d cycles with %0d words outstanding",
               TIMEOUT_CYCLES, exp_q.size());
      $display("Test failed");
      $fatal(1, "simulation did not finish in time");
   end

   // ----------------------------------------------------------
   // Test sequence.
   // ----------------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic        err;
      rst        = 1'b1;
      in_tdata   = '0;
      in_tvalid  = 1'b0;
      in_tlast   = 1'b0;
      out_tready = 1'b1;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      out_beats  = 0;
      lfsr_state = 32'h60de_0a2a;
      cur_mode   = 1'b0;
      cur_gain   = 16'sd1;
      cur_shift  = 5'd0;
      cur_offset = 16'sd0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset state.
      assert (!out_tvalid && in_tready)
         else fail_now($sformatf("after reset out_tvalid %b in_tready %b", out_tvalid, in_tready));
      check_config();
      check_reg(`REG_COUNT, 32'h0);

      // Real mode, large gain then small gain.
      set_config(1'b0, 16'sh7abc, 5'd2, -16'sd300);
      send_words(N_REAL_A, 1'b0);
      drain(1'b0);
      set_config(1'b0, -16'sd3, 5'd17, 16'sh7fff);
      send_words(N_REAL_B, 1'b0);
      drain(1'b0);

      // Complex mode, lanes saturate on their own.
      set_config(1'b1, 16'sh4000, 5'd10, 16'sh0100);
      send_words(N_CPLX, 1'b0);
      drain(1'b0);

      // Back-pressure in both modes.
      set_config(1'b1, -16'sd2, 5'd0, -16'sd32768);
      send_words(N_CPLX_BP, 1'b1);
      drain(1'b1);
      set_config(1'b0, 16'sh7fff, 5'd1, -16'sd5);
      send_words(N_REAL_BP, 1'b1);
      drain(1'b1);

      // Counter matches output beats, then clears.
      check_reg(`REG_COUNT, 32'(out_beats));
      reg_write(`REG_COUNT, 32'h0);
      out_beats = 0;
      check_reg(`REG_COUNT, 32'h0);

      // Unmapped offset flags an error and changes nothing.
      apb_access(8'h14, 1'b1, 32'hdead_beef, rd, err);
      assert (err) else fail_now("no pslverr on write to offset 14");
      apb_access(8'h14, 1'b0, 32'h0, rd, err);
      assert (err) else fail_now("no pslverr on read from offset 14");
      check_config();

      send_words(N_AFTER, 1'b1);
      drain(1'b1);
      check_reg(`REG_COUNT, 32'(out_beats));

      // Any stray extra beat shows up in the scoreboard here.
      repeat (4) @(posedge clk);
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire
